/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal -j 0
TOP      := tb_hdc_bundler
FILELIST := sim.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail decided from the log
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^Test OK$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim.f */
src/hdc_pkg.sv
src/hdc_cmd_decode.sv
src/vote_tally.sv
src/dim_counter.sv
src/bundle_exec.sv
src/bundle_result.sv
src/hdc_bundler_top.sv
verif/clk_gen.sv
verif/tb_hdc_bundler.sv

/* src/bundle_exec.sv */
`default_nettype none

module bundle_exec
    import hdc_pkg::*;
    #(
    parameter int cores = default_cores,
    parameter int dims  = default_dims,
    parameter int w     = default_w
) (
    input  logic                clk,
    input  logic                rst,
    input  exec_t               exec,
    output logic                done,
    output logic                err,
    output logic [max_dims-1:0] hv
);

    // launch-qualified controls for the counters
    logic clear_go;
    logic store_go;

    // completion tracking with one bit per pipeline stage
    logic [2:0] go_sr;
    logic [2:0] err_sr;

    // sign bit from each dimension
    logic [dims-1:0] sign_vec;

    // flags stay set in exec so they only act on the go cycle
    assign clear_go = exec.go & exec.clear;
    assign store_go = exec.go & exec.store;

    for (genvar d = 0; d < dims; d++) begin : g_dim
        dim_counter #(
            .cores (cores),
            .w     (w)
        ) u_dim_counter (
            .clk        (clk),
            .rst        (rst),
            .clear      (clear_go),
            .store_flag (store_go),
            .store      (exec.store_mask[cores-1:0]),
            .result     (exec.votes[d][cores-1:0]),
            .sign_bit   (sign_vec[d])
        );
    end

    // three stages match vote, tally and counter update
    always_ff @(posedge clk) begin
        if (rst) begin
            go_sr <= '0;
        end else begin
            go_sr <= {go_sr[1:0], exec.go};
        end
    end

    // err rides along with go
    always_ff @(posedge clk) begin
        err_sr <= {err_sr[1:0], exec.err};
    end

    assign done = go_sr[2];
    assign err  = err_sr[2];

    // unused upper dimensions read as zero
    assign hv = max_dims'(sign_vec);

endmodule

`default_nettype wire

/* src/bundle_result.sv */
`default_nettype none

module bundle_result
    import hdc_pkg::*;
    (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  logic                done,
    input  logic                err,
    input  logic [max_dims-1:0] hv,
    output logic                ack,
    output rsp_t                rsp,
    output logic                release_done
);

    // ack phase of the four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            ack          <= 1'b0;
            rsp          <= '0;
            release_done <= 1'b0;
        end else begin
            release_done <= 1'b0;
            if (done) begin
                // counters already updated so the signs are final
                rsp.hv  <= hv;
                rsp.err <= err;
                ack     <= 1'b1;
            end else if (ack && !req) begin
                // requester dropped req so close out and free decode
                ack          <= 1'b0;
                release_done <= 1'b1;
            end
            // req still high keeps ack and rsp as they are
        end
    end

endmodule

`default_nettype wire

/* src/dim_counter.sv */
`default_nettype none

module dim_counter
    import hdc_pkg::*;
    #(
    parameter int cores = default_cores,
    parameter int w     = default_w
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic             store_flag,
    input  logic [cores-1:0] store,
    input  logic [cores-1:0] result,
    output logic             sign_bit
);

    localparam int tw = tally_w(cores);

    // store delay line with votes at store_n and the add at store_nn
    logic store_n;
    logic store_nn;

    // clear travels the same two stages
    logic clear_n;
    logic clear_nn;

    logic signed [tw-1:0] tally;

    // bundling counter that wraps if w is too small
    logic signed [w-1:0]  count;

    vote_tally #(
        .cores (cores)
    ) u_vote_tally (
        .clk      (clk),
        .store_en (store_flag),
        .store    (store),
        .result   (result),
        .tally    (tally)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            store_n  <= 1'b0;
            store_nn <= 1'b0;
            clear_n  <= 1'b0;
            clear_nn <= 1'b0;
        end else begin
            store_n  <= store_flag;
            store_nn <= store_n;
            clear_n  <= clear;
            clear_nn <= clear_n;
        end
    end

    // clear and add share a stage but never come from one command
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear_nn) begin
            count <= '0;
        end else if (store_nn) begin
            // tally sign-extends to w
            count <= count + tally;
        end
    end

    // negative counter reads as 1
    assign sign_bit = count[w-1];

endmodule

`default_nettype wire

/* src/hdc_bundler_top.sv */
`default_nettype none

module hdc_bundler_top
    import hdc_pkg::*;
    #(
    parameter int cores = default_cores,
    parameter int dims  = default_dims,
    parameter int w     = default_w
) (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  cmd_t cmd,
    output logic ack,
    output rsp_t rsp
);

    exec_t               exec;
    logic                done;
    logic                err;
    logic [max_dims-1:0] hv;
    logic                release_done;

    // request side with one launch per command
    hdc_cmd_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .cmd          (cmd),
        .release_done (release_done),
        .exec         (exec)
    );

    // per-dimension counters
    bundle_exec #(
        .cores (cores),
        .dims  (dims),
        .w     (w)
    ) u_exec (
        .clk  (clk),
        .rst  (rst),
        .exec (exec),
        .done (done),
        .err  (err),
        .hv   (hv)
    );

    // response and ack
    bundle_result u_result (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .done         (done),
        .err          (err),
        .hv           (hv),
        .ack          (ack),
        .rsp          (rsp),
        .release_done (release_done)
    );

endmodule

`default_nettype wire

/* src/hdc_cmd_decode.sv */
`default_nettype none

module hdc_cmd_decode
    import hdc_pkg::*;
    (
    input  logic   clk,
    input  logic   rst,
    input  logic   req,
    input  cmd_t   cmd,
    input  logic   release_done,
    output exec_t  exec
);

    dec_state_e state;

    // req registered once before the launch decision
    logic req_q;
    logic launch;

    // launch control flags
    logic go_q;
    logic clear_q;
    logic store_q;
    logic err_q;

    // launch payload
    logic [max_cores-1:0]               mask_q;
    logic [max_dims-1:0][max_cores-1:0] votes_q;

    // only one command in flight
    assign launch = (state == dec_idle) && req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= dec_idle;
            req_q   <= 1'b0;
            go_q    <= 1'b0;
            clear_q <= 1'b0;
            store_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            req_q <= req;
            // go is a single-cycle pulse
            go_q  <= 1'b0;
            case (state)
                dec_idle: begin
                    if (req_q) begin
                        go_q    <= 1'b1;
                        clear_q <= (cmd.op == op_clear);
                        store_q <= (cmd.op == op_bundle);
                        // reserved opcode leaves counters alone
                        err_q   <= (cmd.op == op_rsvd);
                        state   <= dec_busy;
                    end
                end
                dec_busy: begin
                    // wait for result to finish the ack phase
                    if (release_done) begin
                        state <= dec_idle;
                    end
                end
                default: state <= dec_idle;
            endcase
        end
    end

    // payload captured with the launch
    always_ff @(posedge clk) begin
        if (launch) begin
            mask_q  <= cmd.store;
            votes_q <= cmd.votes;
        end
    end

    assign exec = '{go: go_q, clear: clear_q, store: store_q, err: err_q,
                    store_mask: mask_q, votes: votes_q};

endmodule

`default_nettype wire

/* src/hdc_pkg.sv */
`default_nettype none

package hdc_pkg;

    // defaults for the top-level parameters
    localparam int default_cores = 4;
    localparam int default_dims  = 8;
    localparam int default_w     = 12;

    // upper bounds for the packed payload fields
    localparam int max_cores = 16;
    localparam int max_dims  = 32;

    // command opcodes where op_rsvd answers with err set
    typedef enum logic [1:0] {
        op_clear  = 2'd0,
        op_bundle = 2'd1,
        op_read   = 2'd2,
        op_rsvd   = 2'd3
    } opcode_e;

    // decoder handshake states
    typedef enum logic {
        dec_idle = 1'b0,
        dec_busy = 1'b1
    } dec_state_e;

    // request payload held stable while req is high
    typedef struct packed {
        opcode_e                             op;
        logic [max_cores-1:0]                store;
        logic [max_dims-1:0][max_cores-1:0]  votes;
    } cmd_t;

    // one launch into the execute stage
    typedef struct packed {
        logic                                go;
        logic                                clear;
        logic                                store;
        logic                                err;
        logic [max_cores-1:0]                store_mask;
        logic [max_dims-1:0][max_cores-1:0]  votes;
    } exec_t;

    // response payload valid while ack is high
    typedef struct packed {
        logic [max_dims-1:0]  hv;
        logic                 err;
    } rsp_t;

    // tally width covering a sum in -n..+n
    function automatic int tally_w(int n);
        return $clog2(n + 1) + 1;
    endfunction

endpackage

`default_nettype wire

/* src/vote_tally.sv */
`default_nettype none

module vote_tally
    import hdc_pkg::*;
    #(
    parameter int cores = default_cores
) (
    input  logic                             clk,
    input  logic                             store_en,
    input  logic [cores-1:0]                 store,
    input  logic [cores-1:0]                 result,
    output logic signed [tally_w(cores)-1:0] tally
);

    localparam int tw = tally_w(cores);

    // per-core vote in -1..+1
    logic signed [1:0] vote [cores];

    // combinational sum of the held votes
    logic signed [tw-1:0] vote_sum;

    // votes load in the store_n stage
    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int k = 0; k < cores; k++) begin
                if (!store[k]) begin
                    // core not storing abstains
                    vote[k] <= 2'sd0;
                end else if (result[k]) begin
                    vote[k] <= 2'sd1;
                end else begin
                    vote[k] <= -2'sd1;
                end
            end
        end
    end

    // adder tree over all cores
    always_comb begin
        vote_sum = '0;
        for (int k = 0; k < cores; k++) begin
            vote_sum = vote_sum + vote[k];
        end
    end

    // tally follows the votes one cycle later
    // votes hold between loads so the tally stays put too
    always_ff @(posedge clk) begin
        tally <= vote_sum;
    end

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`default_nettype none

module clk_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    // free-running clock with a 20 ns period by default
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // rst high for the first reset_cycles rising edges
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* verif/tb_hdc_bundler.sv */
`default_nettype none

module tb_hdc_bundler
    import hdc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int cores   = default_cores;
    localparam int dims    = default_dims;
    localparam int w       = default_w;
    // edges from req sampled high to ack raised
    localparam int latency = 5;
    // commands issued by all sequences together
    localparam int n_cmds      = 86;
    localparam int cycle_limit = 20 * n_cmds * 8;

    logic clk;
    logic rst;
    logic req;
    cmd_t cmd;
    logic ack;
    rsp_t rsp;

    // stimulus LFSR seeded with 8
    logic [15:0] lfsr_q = 16'd8;
    // reference counters per dimension
    int   model_cnt [dims] = '{default: 0};
    rsp_t exp_q [$];
    int   cycle = 0;
    int   issued = 0;
    int   req_cycle = 0;
    logic req_d;
    logic ack_d;

    clk_gen #(
        .half_period  (10),
        .reset_cycles (5)
    ) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    hdc_bundler_top #(
        .cores (cores),
        .dims  (dims),
        .w     (w)
    ) i_dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .cmd (cmd),
        .ack (ack),
        .rsp (rsp)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_rsp(input rsp_t got, input rsp_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s: hv %h err %b, expected hv %h err %b",
                                $time, what, got.hv, got.err, exp.hv, exp.err));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] %0t ack latency %0d cycles, expected %0d",
                                $time, got, exp));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v[i] = lfsr_q[0];
        end
        return v;
    endfunction

    // stored 1 votes +1, stored 0 votes -1 and an idle core votes 0
    function automatic rsp_t ref_model(input cmd_t c);
        rsp_t r;
        int   sum;
        r = '0;
        case (c.op)
            op_clear: begin
                for (int d = 0; d < dims; d++) model_cnt[d] = 0;
            end
            op_bundle: begin
                for (int d = 0; d < dims; d++) begin
                    sum = 0;
                    for (int k = 0; k < cores; k++) begin
                        if (c.store[k]) sum += c.votes[d][k] ? 1 : -1;
                    end
                    model_cnt[d] += sum;
                end
            end
            op_read: begin
            end
            default: r.err = 1'b1;
        endcase
        // hv bit set where the counter is negative
        for (int d = 0; d < dims; d++) r.hv[d] = (model_cnt[d] < 0);
        return r;
    endfunction

    function automatic cmd_t plain_cmd(input opcode_e op);
        cmd_t c;
        c = '0;
        c.op = op;
        return c;
    endfunction

    function automatic cmd_t random_bundle(input logic [max_cores-1:0] mask);
        cmd_t        c;
        logic [31:0] bits;
        c = '0;
        c.op = op_bundle;
        c.store = mask;
        for (int d = 0; d < dims; d++) begin
            bits = rand_bits(cores);
            c.votes[d] = bits[max_cores-1:0];
        end
        return c;
    endfunction

    // four-phase handshake driven on falling edges
    task automatic send_cmd(input cmd_t c, input int hold, output rsp_t got);
        exp_q.push_back(ref_model(c));
        issued++;
        @(negedge clk);
        cmd = c;
        req = 1'b1;
        while (!ack) @(negedge clk);
        got = rsp;
        // back-pressure keeps req up past ack
        repeat (hold) begin
            @(negedge clk);
            if (!ack) abort_run("ack dropped while req was still held high");
            if (rsp !== got) abort_run("rsp changed while req was still held high");
        end
        req = 1'b0;
        while (ack) @(negedge clk);
        @(negedge clk);
    endtask

    // timeout watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    // response monitor sampling values as they were before the edge
    always @(posedge clk) begin
        rsp_t exp;
        if (rst) begin
            req_d = 1'b0;
            ack_d = 1'b0;
        end else begin
            if (req && !req_d) req_cycle = cycle;
            if (ack && !ack_d) begin
                // ack is seen one edge after the edge that raised it
                check_latency(cycle - req_cycle - 1, latency);
                if (exp_q.size() == 0) begin
                    abort_run("ack rose with no command pending");
                end else begin
                    exp = exp_q.pop_front();
                    check_rsp(rsp, exp, "response");
                end
            end
            req_d = req;
            ack_d = ack;
        end
    end

    initial begin
        rsp_t                 got;
        rsp_t                 got_a;
        rsp_t                 prev;
        rsp_t                 exp;
        cmd_t                 c;
        cmd_t                 c_flip;
        logic [max_cores-1:0] mask;
        logic [31:0]          bits;
        req = 1'b0;
        cmd = '0;
        wait (!rst);
        @(negedge clk);
        check_rsp(rsp, '0, "response after reset");

        // read straight after reset
        send_cmd(plain_cmd(op_read), 0, got);
        check_rsp(got, '0, "read after reset");

        // all cores storing with reads interleaved
        for (int i = 0; i < 40; i++) begin
            send_cmd(random_bundle({max_cores{1'b1}}), 0, got);
            if (i % 4 == 3) send_cmd(plain_cmd(op_read), 0, got);
        end

        // flipped bits of idle cores under a partial mask must not matter
        for (int t = 0; t < 6; t++) begin
            bits = rand_bits(cores);
            mask = bits[max_cores-1:0];
            if (mask[cores-1:0] == {cores{1'b1}}) mask[0] = 1'b0;
            c = random_bundle(mask);
            c_flip = c;
            for (int d = 0; d < dims; d++) begin
                c_flip.votes[d][cores-1:0] = c.votes[d][cores-1:0] ^ ~mask[cores-1:0];
            end
            send_cmd(plain_cmd(op_clear), 0, got);
            send_cmd(c, 0, got_a);
            send_cmd(plain_cmd(op_clear), 0, got);
            send_cmd(c_flip, 0, got);
            check_rsp(got, got_a, "bundle with idle-core bits flipped");
        end

        // clear then accumulate again from zero
        send_cmd(plain_cmd(op_clear), 0, got);
        check_rsp(got, '0, "clear");
        for (int i = 0; i < 4; i++) begin
            send_cmd(random_bundle({max_cores{1'b1}}), 0, got);
        end
        send_cmd(plain_cmd(op_read), 0, prev);

        // reserved opcode sets err and leaves counters untouched
        for (int i = 0; i < 2; i++) begin
            c = random_bundle({max_cores{1'b1}});
            c.op = op_rsvd;
            send_cmd(c, 0, got);
            exp = prev;
            exp.err = 1'b1;
            check_rsp(got, exp, "reserved opcode");
        end
        send_cmd(plain_cmd(op_read), 0, got);

        // req held high well past ack
        send_cmd(random_bundle({max_cores{1'b1}}), 6, got);
        send_cmd(plain_cmd(op_read), 3, got);

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0 || issued != n_cmds) begin
            abort_run("commands were left without a response");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
